/* build.f */
hw/axi_wrap_pkg.sv
hw/mem_port_if.sv
hw/fetch_axi_master.sv
hw/data_axi_master.sv
hw/stall_ctrl.sv
hw/axi_cpu_wrapper.sv
dv/axi_slave_model.sv
dv/tb_axi_cpu_wrapper.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, result taken from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_axi_cpu_wrapper -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" sim.log; then
  exit 0
fi
exit 1

/* dv/tb_axi_cpu_wrapper.sv */
module tb_axi_cpu_wrapper
  import axi_wrap_pkg::*;
();

  localparam int unsigned              mem_words = 256;
  localparam logic [axi_addr_bits-1:0] err_base  = 32'h0000_1000;
  localparam logic [axi_data_bits-1:0] fill_step = 32'h0001_0003;
  localparam int unsigned              seed      = 32'hebc6f754;
  localparam int rst_cycles     = 16;
  localparam int n_fetch        = 20;
  localparam int n_wr           = 12;
  localparam int n_mix          = 24;
  localparam int n_txn          = n_fetch + 2 * n_wr + 3 + 2 * n_mix;
  localparam int timeout_cycles = 2 * rst_cycles + 200 * n_txn;

  // one entry per issued request, popped at its done pulse.
  typedef struct packed {
    logic            check;
    logic            is_err;
    logic [xlen-1:0] value;
  } exp_t;

  logic ACLK;
  logic ARESETn;
  logic [axi_addr_bits-1:0] imem_addr, dmem_addr;
  logic imem_ren, dmem_ren, dmem_wen, imem_done, dmem_done, stall, bus_error;
  logic [axi_strb_bits-1:0] dmem_wstrb, WSTRB_M0, WSTRB_M1;
  logic [xlen-1:0] imem_rdata, dmem_rdata, dmem_wdata;
  logic [axi_addr_bits-1:0] ARADDR_M0, AWADDR_M0, ARADDR_M1, AWADDR_M1;
  logic [axi_data_bits-1:0] RDATA_M0, WDATA_M0, RDATA_M1, WDATA_M1;
  axi_resp_t RRESP_M0, BRESP_M0, RRESP_M1, BRESP_M1;
  logic ARVALID_M0, ARREADY_M0, RVALID_M0, RREADY_M0, AWVALID_M0, AWREADY_M0;
  logic WVALID_M0, WREADY_M0, BVALID_M0, BREADY_M0;
  logic ARVALID_M1, ARREADY_M1, RVALID_M1, RREADY_M1, AWVALID_M1, AWREADY_M1;
  logic WVALID_M1, WREADY_M1, BVALID_M1, BREADY_M1;

  exp_t imem_exp_q[$];
  exp_t dmem_exp_q[$];
  logic [xlen-1:0] shadow [mem_words];  // expected M1 contents.
  logic [xlen-1:0] last_i, last_d;      // last good word per port.
  logic [axi_addr_bits-1:0] addr_q[$];
  string test_name;
  int errors, checks, tests_run, tests_failed, errs_at_start, cycles;
  logic m1_open, err_issued, err_seen;

  axi_cpu_wrapper i_axi_cpu_wrapper (.*);

  axi_slave_model #(.mem_words(mem_words), .err_base(err_base), .fill_step(fill_step)) u_mem_m0 (
    .ACLK, .ARESETn,
    .ARADDR(ARADDR_M0), .ARVALID(ARVALID_M0), .ARREADY(ARREADY_M0),
    .RDATA(RDATA_M0), .RRESP(RRESP_M0), .RVALID(RVALID_M0), .RREADY(RREADY_M0),
    .AWADDR(AWADDR_M0), .AWVALID(AWVALID_M0), .AWREADY(AWREADY_M0),
    .WDATA(WDATA_M0), .WSTRB(WSTRB_M0), .WVALID(WVALID_M0), .WREADY(WREADY_M0),
    .BRESP(BRESP_M0), .BVALID(BVALID_M0), .BREADY(BREADY_M0)
  );

  axi_slave_model #(.mem_words(mem_words), .err_base(err_base), .fill_step(fill_step)) u_mem_m1 (
    .ACLK, .ARESETn,
    .ARADDR(ARADDR_M1), .ARVALID(ARVALID_M1), .ARREADY(ARREADY_M1),
    .RDATA(RDATA_M1), .RRESP(RRESP_M1), .RVALID(RVALID_M1), .RREADY(RREADY_M1),
    .AWADDR(AWADDR_M1), .AWVALID(AWVALID_M1), .AWREADY(AWREADY_M1),
    .WDATA(WDATA_M1), .WSTRB(WSTRB_M1), .WVALID(WVALID_M1), .WREADY(WREADY_M1),
    .BRESP(BRESP_M1), .BVALID(BVALID_M1), .BREADY(BREADY_M1)
  );

  always #4 ACLK = ~ACLK;

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic int unsigned word_of(logic [axi_addr_bits-1:0] addr);
    return (addr >> 2) % mem_words;
  endfunction

  function automatic logic [xlen-1:0] merge_bytes(logic [xlen-1:0] old_w,
                                                  logic [xlen-1:0] new_w,
                                                  logic [axi_strb_bits-1:0] strb);
    logic [xlen-1:0] res;
    res = old_w;
    for (int b = 0; b < axi_strb_bits; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // preload pattern for M0, shadow contents for M1.
  function automatic logic [xlen-1:0] expected_word(logic [axi_addr_bits-1:0] addr,
                                                    logic from_data);
    int unsigned idx;
    idx = word_of(addr);
    return from_data ? shadow[idx] : xlen'(idx) * fill_step;
  endfunction

  function automatic logic [axi_addr_bits-1:0] rand_addr(int unsigned span);
    return axi_addr_bits'($urandom_range(span - 1)) << 2;
  endfunction

  task automatic check_value(string what, logic [xlen-1:0] exp_v, logic [xlen-1:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      $display("Fail %s (%s): expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic begin_test(string name);
    test_name     = name;
    errs_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %-14s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-14s FAILED with %0d errors", test_name, errors - errs_at_start);
    end
  endtask

  // back into reset mid-run. both memories reload their preload.
  task automatic pulse_reset();
    ARESETn    = 1'b0;
    err_issued = 1'b0;
    err_seen   = 1'b0;
    for (int i = 0; i < mem_words; i++) shadow[i] = xlen'(i) * fill_step;
    repeat (rst_cycles) @(negedge ACLK);
    ARESETn = 1'b1;
  endtask

  // ==========================================================================
  // request drivers, called on a falling edge
  // ==========================================================================
  task automatic fetch_word(logic [axi_addr_bits-1:0] addr, logic is_err);
    exp_t e;
    e.check  = 1'b1;
    e.is_err = is_err;
    e.value  = is_err ? last_i : expected_word(addr, 1'b0);
    if (!is_err) last_i = e.value;
    if (is_err) err_issued = 1'b1;
    imem_exp_q.push_back(e);
    imem_addr = addr;
    imem_ren  = 1'b1;
    do @(negedge ACLK); while (!imem_done);  // held until done.
    imem_ren = 1'b0;
  endtask

  task automatic data_access(logic [axi_addr_bits-1:0] addr, logic wr,
                             logic [axi_strb_bits-1:0] strb, logic [xlen-1:0] wdata,
                             logic is_err);
    exp_t e;
    e.check  = !wr;
    e.is_err = is_err;
    e.value  = '0;
    if (wr) begin
      shadow[word_of(addr)] = merge_bytes(shadow[word_of(addr)], wdata, strb);
    end else begin
      e.value = is_err ? last_d : expected_word(addr, 1'b1);
      if (!is_err) last_d = e.value;
    end
    if (is_err) err_issued = 1'b1;
    dmem_exp_q.push_back(e);
    dmem_addr  = addr;
    dmem_ren   = !wr;
    dmem_wen   = wr;
    dmem_wstrb = strb;
    dmem_wdata = wdata;
    do @(negedge ACLK); while (!dmem_done);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  // ==========================================================================
  // monitors and comparison
  // ==========================================================================
  // M1 open from first valid until its R or B handshake.
  always @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) m1_open <= 1'b0;
    else if ((RVALID_M1 && RREADY_M1) || (BVALID_M1 && BREADY_M1)) m1_open <= 1'b0;
    else if (ARVALID_M1 || AWVALID_M1) m1_open <= 1'b1;
  end

  always @(posedge ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  always @(negedge ACLK) begin
    exp_t e;
    logic pend_now;
    pend_now = m1_open || ARVALID_M1 || AWVALID_M1 || WVALID_M1;
    check_value("stall rule", 32'(!(RVALID_M0 && RREADY_M0 && !pend_now)), 32'(stall));
    // M0 is read-only, its write channel stays idle.
    check_value("M0 write idle", 32'h1, 32'({AWVALID_M0, WVALID_M0, BREADY_M0}));
    check_value("M0 write payload", 32'h0, 32'(|{AWADDR_M0, WDATA_M0, WSTRB_M0}));
    if (ARESETn) begin
      if (err_seen) check_value("sticky bus_error", 32'h1, 32'(bus_error));
      else if (!err_issued) check_value("bus_error", 32'h0, 32'(bus_error));
    end
    if (imem_done) begin
      assert (imem_exp_q.size() != 0) else begin
        $display("%s: fetch done pulse with no fetch outstanding", test_name);
        errors++;
      end
      if (imem_exp_q.size() != 0) begin
        e = imem_exp_q.pop_front();
        check_value("imem_rdata", e.value, imem_rdata);
        if (e.is_err) check_value("bus_error after fetch", 32'h1, 32'(bus_error));
        if (e.is_err) err_seen = 1'b1;
      end
    end
    if (dmem_done) begin
      assert (dmem_exp_q.size() != 0) else begin
        $display("%s: data done pulse with no access outstanding", test_name);
        errors++;
      end
      if (dmem_exp_q.size() != 0) begin
        e = dmem_exp_q.pop_front();
        if (e.check) check_value("dmem_rdata", e.value, dmem_rdata);
        if (e.is_err) check_value("bus_error after read", 32'h1, 32'(bus_error));
        if (e.is_err) err_seen = 1'b1;
      end
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    logic [axi_addr_bits-1:0] a;
    void'($urandom(seed));
    ACLK       = 1'b0;
    ARESETn    = 1'b0;
    imem_addr  = '0;
    imem_ren   = 1'b0;
    dmem_addr  = '0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    dmem_wstrb = '0;
    dmem_wdata = '0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    tests_failed = 0;
    cycles     = 0;
    err_issued = 1'b0;
    err_seen   = 1'b0;
    last_i     = '0;
    last_d     = '0;
    for (int i = 0; i < mem_words; i++) shadow[i] = xlen'(i) * fill_step;

    begin_test("reset");
    repeat (rst_cycles) @(negedge ACLK);
    check_value("idle outputs in reset", 32'h1,
                32'({ARVALID_M0, ARVALID_M1, AWVALID_M0, AWVALID_M1, WVALID_M0,
                     WVALID_M1, imem_done, dmem_done, bus_error, stall}));
    ARESETn = 1'b1;
    end_test();

    begin_test("fetch");
    for (int n = 0; n < n_fetch; n++) fetch_word(rand_addr(mem_words), 1'b0);
    end_test();

    begin_test("write_read");
    for (int n = 0; n < n_wr; n++) begin
      a = rand_addr(mem_words);
      addr_q.push_back(a);
      data_access(a, 1'b1, axi_strb_bits'($urandom_range(15, 1)), $urandom(), 1'b0);
    end
    while (addr_q.size() != 0) data_access(addr_q.pop_front(), 1'b0, '0, '0, 1'b0);
    end_test();

    begin_test("error_window");
    fetch_word(err_base + 32'h10, 1'b1);
    repeat (4) @(negedge ACLK);  // flag must hold.
    pulse_reset();  // clears the flag so the data side sets it again.
    data_access(rand_addr(mem_words), 1'b0, '0, '0, 1'b0);
    data_access(err_base + 32'h20, 1'b0, '0, '0, 1'b1);
    repeat (4) @(negedge ACLK);
    end_test();

    begin_test("interleaved");
    fork
      for (int n = 0; n < n_mix; n++) fetch_word(rand_addr(mem_words), 1'b0);
      for (int n = 0; n < n_mix; n++) begin
        a = rand_addr(8);  // small range so reads hit fresh writes.
        if ($urandom_range(1) == 1)
          data_access(a, 1'b1, axi_strb_bits'($urandom_range(15, 1)), $urandom(), 1'b0);
        else
          data_access(a, 1'b0, '0, '0, 1'b0);
      end
    join
    end_test();

    repeat (2) @(negedge ACLK);
    assert (imem_exp_q.size() == 0 && dmem_exp_q.size() == 0) else begin
      $display("requests left without a done pulse");
      errors++;
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* dv/axi_slave_model.sv */
module axi_slave_model
  import axi_wrap_pkg::*;
#(
  parameter int unsigned              mem_words = 256,
  parameter logic [axi_addr_bits-1:0] err_base  = 32'h0000_1000,
  parameter logic [axi_data_bits-1:0] fill_step = 32'h0001_0003
) (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic [axi_addr_bits-1:0] ARADDR,
  input  logic                     ARVALID,
  output logic                     ARREADY,
  output logic [axi_data_bits-1:0] RDATA,
  output axi_resp_t                RRESP,
  output logic                     RVALID,
  input  logic                     RREADY,
  input  logic [axi_addr_bits-1:0] AWADDR,
  input  logic                     AWVALID,
  output logic                     AWREADY,
  input  logic [axi_data_bits-1:0] WDATA,
  input  logic [axi_strb_bits-1:0] WSTRB,
  input  logic                     WVALID,
  output logic                     WREADY,
  output axi_resp_t                BRESP,
  output logic                     BVALID,
  input  logic                     BREADY
);

  logic [axi_data_bits-1:0] mem [mem_words];
  logic [axi_addr_bits-1:0] rd_addr;
  logic [axi_addr_bits-1:0] wr_addr;
  logic [axi_data_bits-1:0] wr_data;
  logic [axi_strb_bits-1:0] wr_strb;
  logic                     rd_busy;
  logic                     aw_got;
  logic                     w_got;
  int unsigned              r_wait;
  int unsigned              b_wait;

  function automatic int unsigned word_index(logic [axi_addr_bits-1:0] a);
    return (a >> 2) % mem_words;  // word address wraps on the depth.
  endfunction

  // reads in the 256-byte window at err_base answer SLVERR.
  function automatic logic in_err_window(logic [axi_addr_bits-1:0] a);
    return a[axi_addr_bits-1:8] == err_base[axi_addr_bits-1:8];
  endfunction

  // ==========================================================================
  // read channels, one read at a time
  // ==========================================================================
  always @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ARREADY <= 1'b0;
      RVALID  <= 1'b0;
      RDATA   <= '0;
      RRESP   <= axi_resp_okay;
      rd_busy <= 1'b0;
      rd_addr <= '0;
      r_wait  <= 0;
    end else begin
      ARREADY <= !rd_busy && !(ARVALID && ARREADY) && ($urandom_range(3) == 0);
      if (ARVALID && ARREADY) begin
        rd_busy <= 1'b1;
        rd_addr <= ARADDR;
        r_wait  <= $urandom_range(6);
      end else if (rd_busy && !RVALID) begin
        if (r_wait == 0) begin
          RVALID <= 1'b1;
          RRESP  <= in_err_window(rd_addr) ? axi_resp_slverr : axi_resp_okay;
          RDATA  <= in_err_window(rd_addr) ? '1 : mem[word_index(rd_addr)];
        end else begin
          r_wait <= r_wait - 1;  // response delay.
        end
      end
      if (RVALID && RREADY) begin
        RVALID  <= 1'b0;
        rd_busy <= 1'b0;
      end
    end
  end

  // ==========================================================================
  // write channels and memory
  // ==========================================================================
  always @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      AWREADY <= 1'b0;
      WREADY  <= 1'b0;
      BVALID  <= 1'b0;
      BRESP   <= axi_resp_okay;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      wr_addr <= '0;
      wr_data <= '0;
      wr_strb <= '0;
      b_wait  <= 0;
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= axi_data_bits'(i) * fill_step;  // preload pattern.
      end
    end else begin
      AWREADY <= !aw_got && !(AWVALID && AWREADY) && ($urandom_range(3) == 0);
      WREADY  <= !w_got && !(WVALID && WREADY) && ($urandom_range(3) == 0);
      if (AWVALID && AWREADY) begin
        aw_got  <= 1'b1;
        wr_addr <= AWADDR;
        b_wait  <= $urandom_range(6);
      end
      if (WVALID && WREADY) begin
        w_got   <= 1'b1;
        wr_data <= WDATA;
        wr_strb <= WSTRB;
      end
      // commit once both halves are in, then answer on B.
      if (aw_got && w_got && !BVALID) begin
        if (b_wait == 0) begin
          for (int b = 0; b < axi_strb_bits; b++) begin
            if (wr_strb[b]) mem[word_index(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
          end
          BVALID <= 1'b1;
        end else begin
          b_wait <= b_wait - 1;
        end
      end
      if (BVALID && BREADY) begin
        BVALID <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
    end
  end

endmodule

/* hw/axi_cpu_wrapper.sv */
module axi_cpu_wrapper
  import axi_wrap_pkg::*;
(
  input  logic                     ACLK,
  input  logic                     ARESETn,

  // core fetch port.
  input  logic [axi_addr_bits-1:0] imem_addr,
  input  logic                     imem_ren,
  output logic [xlen-1:0]          imem_rdata,
  output logic                     imem_done,

  // core data port.
  input  logic [axi_addr_bits-1:0] dmem_addr,
  input  logic                     dmem_ren,
  input  logic                     dmem_wen,
  input  logic [axi_strb_bits-1:0] dmem_wstrb,
  input  logic [xlen-1:0]          dmem_wdata,
  output logic [xlen-1:0]          dmem_rdata,
  output logic                     dmem_done,

  output logic                     stall,
  output logic                     bus_error,

  // ==========================================================================
  // master 0, instruction fetch
  // ==========================================================================
  output logic [axi_addr_bits-1:0] ARADDR_M0,
  output logic                     ARVALID_M0,
  input  logic                     ARREADY_M0,
  input  logic [axi_data_bits-1:0] RDATA_M0,
  input  axi_resp_t                RRESP_M0,
  input  logic                     RVALID_M0,
  output logic                     RREADY_M0,
  output logic [axi_addr_bits-1:0] AWADDR_M0,
  output logic                     AWVALID_M0,
  input  logic                     AWREADY_M0,
  output logic [axi_data_bits-1:0] WDATA_M0,
  output logic [axi_strb_bits-1:0] WSTRB_M0,
  output logic                     WVALID_M0,
  input  logic                     WREADY_M0,
  input  axi_resp_t                BRESP_M0,
  input  logic                     BVALID_M0,
  output logic                     BREADY_M0,

  // ==========================================================================
  // master 1, data access
  // ==========================================================================
  output logic [axi_addr_bits-1:0] ARADDR_M1,
  output logic                     ARVALID_M1,
  input  logic                     ARREADY_M1,
  input  logic [axi_data_bits-1:0] RDATA_M1,
  input  axi_resp_t                RRESP_M1,
  input  logic                     RVALID_M1,
  output logic                     RREADY_M1,
  output logic [axi_addr_bits-1:0] AWADDR_M1,
  output logic                     AWVALID_M1,
  input  logic                     AWREADY_M1,
  output logic [axi_data_bits-1:0] WDATA_M1,
  output logic [axi_strb_bits-1:0] WSTRB_M1,
  output logic                     WVALID_M1,
  input  logic                     WREADY_M1,
  input  axi_resp_t                BRESP_M1,
  input  logic                     BVALID_M1,
  output logic                     BREADY_M1
);

  logic fetch_resp;
  logic fetch_err;
  logic data_pending;
  logic data_err;

  mem_port_if fetch_port ();
  mem_port_if data_port ();

  // fetch side has no write request.
  assign fetch_port.addr  = imem_addr;
  assign fetch_port.ren   = imem_ren;
  assign fetch_port.wen   = 1'b0;
  assign fetch_port.wstrb = strb_rst_val;
  assign fetch_port.wdata = word_rst_val;
  assign imem_rdata       = fetch_port.rdata;
  assign imem_done        = fetch_port.done;

  assign data_port.addr  = dmem_addr;
  assign data_port.ren   = dmem_ren;
  assign data_port.wen   = dmem_wen;
  assign data_port.wstrb = dmem_wstrb;
  assign data_port.wdata = dmem_wdata;
  assign dmem_rdata      = data_port.rdata;
  assign dmem_done       = data_port.done;

  // M0 never writes; B is still accepted.
  assign AWADDR_M0  = addr_rst_val;
  assign AWVALID_M0 = 1'b0;
  assign WDATA_M0   = word_rst_val;
  assign WSTRB_M0   = strb_rst_val;
  assign WVALID_M0  = 1'b0;
  assign BREADY_M0  = 1'b1;

  fetch_axi_master u_fetch (
    .ACLK, .ARESETn, .port(fetch_port),
    .ARADDR_M0, .ARVALID_M0, .ARREADY_M0,
    .RDATA_M0, .RRESP_M0, .RVALID_M0, .RREADY_M0,
    .fetch_resp, .fetch_err
  );

  data_axi_master u_data (
    .ACLK, .ARESETn, .port(data_port),
    .ARADDR_M1, .ARVALID_M1, .ARREADY_M1,
    .RDATA_M1, .RRESP_M1, .RVALID_M1, .RREADY_M1,
    .AWADDR_M1, .AWVALID_M1, .AWREADY_M1,
    .WDATA_M1, .WSTRB_M1, .WVALID_M1, .WREADY_M1,
    .BRESP_M1, .BVALID_M1, .BREADY_M1,
    .data_pending, .data_err
  );

  stall_ctrl u_stall (
    .ACLK, .ARESETn,
    .fetch_resp, .fetch_err, .data_pending, .data_err,
    .stall, .bus_error
  );

endmodule

/* hw/stall_ctrl.sv */
module stall_ctrl (
  input  logic ACLK,
  input  logic ARESETn,

  // fetch master status.
  input  logic fetch_resp,
  input  logic fetch_err,

  // data master status.
  input  logic data_pending,
  input  logic data_err,

  output logic stall,
  output logic bus_error
);

  logic any_err;

  // ==========================================================================
  // global stall
  // ==========================================================================
  // the core advances only in the cycle a fetch returns while the data
  // side is idle. every other cycle is held.
  assign stall = !(fetch_resp && !data_pending);

  // ==========================================================================
  // sticky bus error
  // ==========================================================================
  assign any_err = fetch_err || data_err;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      bus_error <= 1'b0;
    end else if (any_err) begin
      bus_error <= 1'b1;  // held until the next reset.
    end
  end

endmodule

/* hw/data_axi_master.sv */
module data_axi_master
  import axi_wrap_pkg::*;
(
  input  logic                     ACLK,
  input  logic                     ARESETn,

  mem_port_if.bus                  port,

  // read address channel.
  output logic [axi_addr_bits-1:0] ARADDR_M1,
  output logic                     ARVALID_M1,
  input  logic                     ARREADY_M1,

  // read data channel.
  input  logic [axi_data_bits-1:0] RDATA_M1,
  input  axi_resp_t                RRESP_M1,
  input  logic                     RVALID_M1,
  output logic                     RREADY_M1,

  // write address channel.
  output logic [axi_addr_bits-1:0] AWADDR_M1,
  output logic                     AWVALID_M1,
  input  logic                     AWREADY_M1,

  // write data channel.
  output logic [axi_data_bits-1:0] WDATA_M1,
  output logic [axi_strb_bits-1:0] WSTRB_M1,
  output logic                     WVALID_M1,
  input  logic                     WREADY_M1,

  // write response channel.
  input  axi_resp_t                BRESP_M1,
  input  logic                     BVALID_M1,
  output logic                     BREADY_M1,

  // status toward the stall controller.
  output logic                     data_pending,
  output logic                     data_err
);

  logic rd_pending;
  logic wr_pending;
  logic launch;
  logic rd_launch;
  logic wr_launch;
  logic r_hs;
  logic b_hs;

  assign r_hs = RVALID_M1 && RREADY_M1;
  assign b_hs = BVALID_M1 && BREADY_M1;

  // one access at a time; write takes priority over read.
  assign launch    = (port.ren || port.wen) && !rd_pending && !wr_pending && !port.done;
  assign wr_launch = launch && port.wen;
  assign rd_launch = launch && !port.wen;

  // ==========================================================================
  // read path
  // ==========================================================================
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ARADDR_M1  <= addr_rst_val;
      ARVALID_M1 <= 1'b0;
      rd_pending <= 1'b0;
    end else begin
      if (rd_launch) begin
        ARADDR_M1  <= port.addr;
        ARVALID_M1 <= 1'b1;
        rd_pending <= 1'b1;
      end else if (ARVALID_M1 && ARREADY_M1) begin
        ARVALID_M1 <= 1'b0;
      end
      if (r_hs) rd_pending <= 1'b0;
    end
  end

  // ==========================================================================
  // write path
  // ==========================================================================
  // address and data go out together, each drops on its own handshake.
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      AWADDR_M1  <= addr_rst_val;
      AWVALID_M1 <= 1'b0;
      WDATA_M1   <= word_rst_val;
      WSTRB_M1   <= strb_rst_val;
      WVALID_M1  <= 1'b0;
      wr_pending <= 1'b0;
    end else begin
      if (wr_launch) begin
        AWADDR_M1  <= port.addr;
        AWVALID_M1 <= 1'b1;
        WDATA_M1   <= port.wdata;
        WSTRB_M1   <= port.wstrb;
        WVALID_M1  <= 1'b1;
        wr_pending <= 1'b1;
      end else begin
        if (AWVALID_M1 && AWREADY_M1) AWVALID_M1 <= 1'b0;
        if (WVALID_M1 && WREADY_M1) WVALID_M1 <= 1'b0;
      end
      if (b_hs) wr_pending <= 1'b0;  // write closes on the response.
    end
  end

  // ==========================================================================
  // responses and completion
  // ==========================================================================
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      RREADY_M1  <= 1'b0;
      BREADY_M1  <= 1'b0;
      port.done  <= 1'b0;
      port.rdata <= word_rst_val;
    end else begin
      RREADY_M1 <= 1'b1;
      BREADY_M1 <= 1'b1;
      port.done <= r_hs || b_hs;
      if (r_hs && RRESP_M1 == axi_resp_okay) port.rdata <= RDATA_M1;
    end
  end

  assign data_pending = rd_pending || wr_pending;
  assign data_err     = (r_hs && RRESP_M1 != axi_resp_okay) ||
                        (b_hs && BRESP_M1 != axi_resp_okay);

endmodule

/* hw/fetch_axi_master.sv */
module fetch_axi_master
  import axi_wrap_pkg::*;
(
  input  logic                     ACLK,
  input  logic                     ARESETn,

  mem_port_if.bus                  port,

  // read address channel.
  output logic [axi_addr_bits-1:0] ARADDR_M0,
  output logic                     ARVALID_M0,
  input  logic                     ARREADY_M0,

  // read data channel.
  input  logic [axi_data_bits-1:0] RDATA_M0,
  input  axi_resp_t                RRESP_M0,
  input  logic                     RVALID_M0,
  output logic                     RREADY_M0,

  // status toward the stall controller.
  output logic                     fetch_resp,
  output logic                     fetch_err
);

  logic pending;  // fetch launched, response not yet seen.
  logic launch;
  logic r_hs;

  assign r_hs = RVALID_M0 && RREADY_M0;

  // a new fetch is taken only when idle; the done cycle still counts as busy
  // so a request held through done is not issued twice.
  assign launch = port.ren && !pending && !port.done;

  // ==========================================================================
  // read address channel
  // ==========================================================================
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ARADDR_M0  <= addr_rst_val;
      ARVALID_M0 <= 1'b0;
      pending    <= 1'b0;
    end else begin
      if (launch) begin
        ARADDR_M0  <= port.addr;
        ARVALID_M0 <= 1'b1;
        pending    <= 1'b1;
      end else if (ARVALID_M0 && ARREADY_M0) begin
        ARVALID_M0 <= 1'b0;  // address accepted.
      end
      if (r_hs) pending <= 1'b0;
    end
  end

  // ==========================================================================
  // read data channel
  // ==========================================================================
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      RREADY_M0  <= 1'b0;
      port.done  <= 1'b0;
      port.rdata <= word_rst_val;
    end else begin
      RREADY_M0 <= 1'b1;  // always accept read data.
      port.done <= r_hs;
      // error responses leave the last good word in place.
      if (r_hs && RRESP_M0 == axi_resp_okay) port.rdata <= RDATA_M0;
    end
  end

  assign fetch_resp = r_hs;
  assign fetch_err  = r_hs && (RRESP_M0 != axi_resp_okay);

endmodule

/* hw/mem_port_if.sv */
interface mem_port_if
  import axi_wrap_pkg::*;
();

  // request side, driven by the core.
  logic [axi_addr_bits-1:0] addr;
  logic                     ren;
  logic                     wen;
  logic [axi_strb_bits-1:0] wstrb;
  logic [xlen-1:0]          wdata;

  // completion side, driven by the bus master.
  logic [xlen-1:0]          rdata;
  logic                     done;  // one cycle per finished transaction.

  modport core (
    output addr, ren, wen, wstrb, wdata,
    input  rdata, done
  );

  modport bus (
    input  addr, ren, wen, wstrb, wdata,
    output rdata, done
  );

endinterface

/* hw/axi_wrap_pkg.sv */
package axi_wrap_pkg;

  // ==========================================================================
  // bus and core widths
  // ==========================================================================
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_strb_bits = axi_data_bits / 8;  // one strobe per byte.
  localparam int xlen          = 32;

  // ==========================================================================
  // response codes
  // ==========================================================================
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t axi_resp_okay   = 2'b00;
  localparam axi_resp_t axi_resp_exokay = 2'b01;
  localparam axi_resp_t axi_resp_slverr = 2'b10;
  localparam axi_resp_t axi_resp_decerr = 2'b11;

  // ==========================================================================
  // reset values
  // ==========================================================================
  // address registers come up pointing at zero.
  localparam logic [axi_addr_bits-1:0] addr_rst_val = '0;

  // returned data and write payload start cleared.
  localparam logic [xlen-1:0] word_rst_val = '0;

  // no byte lanes enabled out of reset.
  localparam logic [axi_strb_bits-1:0] strb_rst_val = '0;

endpackage
